// ==== executeStage.f ====
+incdir+include
src/execPkg.sv
src/claAdder16.sv
src/aluUnit.sv
src/branchTarget.sv
src/nextPcSelect.sv
src/reqAckSlot.sv
src/executeStage.sv
tests/executeStageTb.sv

// ==== include/exec_defines.svh ====
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// Data, PC and immediate word width
`define EXEC_DATA_W 16

// Raw branch offset field as it leaves decode
`define EXEC_OFF_W 11

// Short offset form, low bits of the raw field
`define EXEC_SHORT_OFF_W 8

`endif

// ==== run.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f executeStage.f \
   --top-module executeStageTb -Mdir obj_dir -o simv
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build returned status $status"
   exit 1
fi

output=$(./obj_dir/simv)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "Simulation returned status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test passed"; then
   exit 0
fi
exit 1

// ==== src/aluUnit.sv ====
`default_nettype none

`include "exec_defines.svh"

module aluUnit
   import execPkg::*;
(
   input  logic [`EXEC_DATA_W-1:0] rsData,
   input  logic [`EXEC_DATA_W-1:0] rtData,
   input  logic [`EXEC_DATA_W-1:0] imm,
   input  logic                    useImm,
   input  aluOpT                   aluOp,
   output logic [`EXEC_DATA_W-1:0] result,
   output logic                    zeroFlag,
   output logic                    signFlag
);

   logic [`EXEC_DATA_W-1:0] opB;
   logic [`EXEC_DATA_W-1:0] addB;
   logic [`EXEC_DATA_W-1:0] addSum;
   logic                    isSub;
   logic [3:0]              shAmt;

   // Operand B from immediate or second register
   assign opB = useImm ? imm : rtData;

   // Subtract as rs + ~B + 1
   assign isSub = (aluOp == aluSub);
   assign addB  = isSub ? ~opB : opB;

   claAdder16 aluAdder (
      .a    (rsData),
      .b    (addB),
      .cIn  (isSub),
      .sum  (addSum),
      .cOut ()
   );

   // Only the low nibble sets the shift distance
   assign shAmt = opB[3:0];

   always_comb begin
      case (aluOp)
         aluAdd:   result = addSum;
         aluSub:   result = addSum;
         aluAnd:   result = rsData & opB;
         aluOr:    result = rsData | opB;
         aluXor:   result = rsData ^ opB;
         aluSll:   result = rsData << shAmt;
         aluSrl:   result = rsData >> shAmt;
         aluPassB: result = opB;
         default:  result = opB;
      endcase
   end

   // Flags from the final result
   assign zeroFlag = (result == '0);
   assign signFlag = result[`EXEC_DATA_W-1];

endmodule

`default_nettype wire

// ==== src/branchTarget.sv ====
`default_nettype none

`include "exec_defines.svh"

module branchTarget
   import execPkg::*;
(
   input  logic [`EXEC_DATA_W-1:0] pc,
   input  logic [`EXEC_OFF_W-1:0]  brOffset,
   input  logic                    shortOff,
   output logic [`EXEC_DATA_W-1:0] target
);

   localparam int shortPad = `EXEC_DATA_W - `EXEC_SHORT_OFF_W;
   localparam int longPad  = `EXEC_DATA_W - `EXEC_OFF_W;

   logic [`EXEC_DATA_W-1:0] offShort;
   logic [`EXEC_DATA_W-1:0] offLong;
   logic [`EXEC_DATA_W-1:0] offExt;

   // Sign extend both forms, then pick by length
   assign offShort = {{shortPad{brOffset[`EXEC_SHORT_OFF_W-1]}},
                      brOffset[`EXEC_SHORT_OFF_W-1:0]};
   assign offLong  = {{longPad{brOffset[`EXEC_OFF_W-1]}}, brOffset};
   assign offExt   = shortOff ? offShort : offLong;

   // PC is already incremented, wraps at 16 bits
   claAdder16 pcAdder (
      .a    (pc),
      .b    (offExt),
      .cIn  (1'b0),
      .sum  (target),
      .cOut ()
   );

endmodule

`default_nettype wire

// ==== src/claAdder16.sv ====
`default_nettype none

module claAdder16 (
   input  logic [15:0] a,
   input  logic [15:0] b,
   input  logic        cIn,
   output logic [15:0] sum,
   output logic        cOut
);

   logic [15:0] gen;
   logic [15:0] prop;
   logic [15:0] carry;
   logic [3:0]  grpGen;
   logic [3:0]  grpProp;
   logic [4:0]  grpCarry;

   assign gen  = a & b;
   assign prop = a ^ b;

   // First level, lookahead inside each 4-bit group
   for (genvar k = 0; k < 4; k++) begin : gGroup
      localparam int base = 4 * k;

      assign grpGen[k] = gen[base+3]
         | (prop[base+3] & gen[base+2])
         | (prop[base+3] & prop[base+2] & gen[base+1])
         | (prop[base+3] & prop[base+2] & prop[base+1] & gen[base]);
      assign grpProp[k] = &prop[base+3:base];

      assign carry[base]   = grpCarry[k];
      assign carry[base+1] = gen[base] | (prop[base] & grpCarry[k]);
      assign carry[base+2] = gen[base+1] | (prop[base+1] & gen[base])
         | (prop[base+1] & prop[base] & grpCarry[k]);
      assign carry[base+3] = gen[base+2] | (prop[base+2] & gen[base+1])
         | (prop[base+2] & prop[base+1] & gen[base])
         | (prop[base+2] & prop[base+1] & prop[base] & grpCarry[k]);
   end

   // Second level across groups
   assign grpCarry[0] = cIn;
   assign grpCarry[1] = grpGen[0] | (grpProp[0] & cIn);
   assign grpCarry[2] = grpGen[1] | (grpProp[1] & grpGen[0])
      | (grpProp[1] & grpProp[0] & cIn);
   assign grpCarry[3] = grpGen[2] | (grpProp[2] & grpGen[1])
      | (grpProp[2] & grpProp[1] & grpGen[0])
      | (grpProp[2] & grpProp[1] & grpProp[0] & cIn);
   assign grpCarry[4] = grpGen[3] | (grpProp[3] & grpCarry[3]);

   assign sum  = prop ^ carry;
   assign cOut = grpCarry[4];

endmodule

`default_nettype wire

// ==== src/execPkg.sv ====
`default_nettype none

`include "exec_defines.svh"

package execPkg;

   // ALU operation codes
   typedef enum logic [2:0] {
      aluAdd   = 3'd0,
      aluSub   = 3'd1,
      aluAnd   = 3'd2,
      aluOr    = 3'd3,
      aluXor   = 3'd4,
      aluSll   = 3'd5,
      aluSrl   = 3'd6,
      aluPassB = 3'd7
   } aluOpT;

   // Branch conditions, codes 6 and 7 behave as never
   typedef enum logic [2:0] {
      brNever  = 3'd0,
      brEq     = 3'd1,
      brNe     = 3'd2,
      brLt     = 3'd3,
      brGe     = 3'd4,
      brAlways = 3'd5
   } brCondT;

   // Decoded operation entering the stage
   typedef struct packed {
      logic [`EXEC_DATA_W-1:0] rsData;
      logic [`EXEC_DATA_W-1:0] rtData;
      logic [`EXEC_DATA_W-1:0] pc;
      logic [`EXEC_DATA_W-1:0] imm;
      logic                    useImm;
      aluOpT                   aluOp;
      brCondT                  brCond;
      logic [`EXEC_OFF_W-1:0]  brOffset;
      logic                    shortOff;
      logic                    jumpReg;
   } execOpT;

   // Result leaving the stage
   typedef struct packed {
      logic [`EXEC_DATA_W-1:0] aluOut;
      logic [`EXEC_DATA_W-1:0] pcNext;
      logic                    taken;
   } execResT;

endpackage

`default_nettype wire

// ==== src/executeStage.sv ====
`default_nettype none

`include "exec_defines.svh"

module executeStage
   import execPkg::*;
(
   input  logic                    clk,
   input  logic                    arstN,
   input  logic                    opReq,
   output logic                    opAck,
   input  logic [`EXEC_DATA_W-1:0] rsData,
   input  logic [`EXEC_DATA_W-1:0] rtData,
   input  logic [`EXEC_DATA_W-1:0] pc,
   input  logic [`EXEC_DATA_W-1:0] imm,
   input  logic                    useImm,
   input  logic                    shortOff,
   input  logic                    jumpReg,
   input  aluOpT                   aluOp,
   input  brCondT                  brCond,
   input  logic [`EXEC_OFF_W-1:0]  brOffset,
   output logic                    resReq,
   input  logic                    resAck,
   output logic [`EXEC_DATA_W-1:0] aluOut,
   output logic [`EXEC_DATA_W-1:0] pcNext,
   output logic                    taken
);

   execOpT                  opIn;
   execOpT                  opHeld;
   logic                    opValid;
   logic                    opDone;
   execResT                 resIn;
   execResT                 resOut;
   logic [`EXEC_DATA_W-1:0] aluResult;
   logic                    zeroFlag;
   logic                    signFlag;
   logic [`EXEC_DATA_W-1:0] brTarget;
   logic [`EXEC_DATA_W-1:0] pcSel;
   logic                    brTaken;

   // Gather loose inputs into one operation word
   assign opIn = '{
      rsData:   rsData,
      rtData:   rtData,
      pc:       pc,
      imm:      imm,
      useImm:   useImm,
      aluOp:    aluOp,
      brCond:   brCond,
      brOffset: brOffset,
      shortOff: shortOff,
      jumpReg:  jumpReg
   };

   reqAckSlot #(.payloadT(execOpT)) opSlot (
      .clk     (clk),
      .arstN   (arstN),
      .inReq   (opReq),
      .inAck   (opAck),
      .inData  (opIn),
      .outReq  (opValid),
      .outAck  (opDone),
      .outData (opHeld)
   );

   aluUnit alu (
      .rsData   (opHeld.rsData),
      .rtData   (opHeld.rtData),
      .imm      (opHeld.imm),
      .useImm   (opHeld.useImm),
      .aluOp    (opHeld.aluOp),
      .result   (aluResult),
      .zeroFlag (zeroFlag),
      .signFlag (signFlag)
   );

   branchTarget brAdd (
      .pc       (opHeld.pc),
      .brOffset (opHeld.brOffset),
      .shortOff (opHeld.shortOff),
      .target   (brTarget)
   );

   nextPcSelect pcMux (
      .pc        (opHeld.pc),
      .target    (brTarget),
      .aluResult (aluResult),
      .zeroFlag  (zeroFlag),
      .signFlag  (signFlag),
      .brCond    (opHeld.brCond),
      .jumpReg   (opHeld.jumpReg),
      .pcNext    (pcSel),
      .taken     (brTaken)
   );

   // Result word straight from the compute blocks
   assign resIn = '{aluOut: aluResult, pcNext: pcSel, taken: brTaken};

   reqAckSlot #(.payloadT(execResT)) resSlot (
      .clk     (clk),
      .arstN   (arstN),
      .inReq   (opValid),
      .inAck   (opDone),
      .inData  (resIn),
      .outReq  (resReq),
      .outAck  (resAck),
      .outData (resOut)
   );

   assign aluOut = resOut.aluOut;
   assign pcNext = resOut.pcNext;
   assign taken  = resOut.taken;

endmodule

`default_nettype wire

// ==== src/nextPcSelect.sv ====
`default_nettype none

`include "exec_defines.svh"

module nextPcSelect
   import execPkg::*;
(
   input  logic [`EXEC_DATA_W-1:0] pc,
   input  logic [`EXEC_DATA_W-1:0] target,
   input  logic [`EXEC_DATA_W-1:0] aluResult,
   input  logic                    zeroFlag,
   input  logic                    signFlag,
   input  brCondT                  brCond,
   input  logic                    jumpReg,
   output logic [`EXEC_DATA_W-1:0] pcNext,
   output logic                    taken
);

   // Condition test on this operation's flags
   always_comb begin
      case (brCond)
         brNever:  taken = 1'b0;
         brEq:     taken = zeroFlag;
         brNe:     taken = ~zeroFlag;
         brLt:     taken = signFlag;
         brGe:     taken = ~signFlag;
         brAlways: taken = 1'b1;
         default:  taken = 1'b0;
      endcase
   end

   // Register jump wins over a taken branch
   always_comb begin
      if (jumpReg) begin
         pcNext = aluResult;
      end else if (taken) begin
         pcNext = target;
      end else begin
         pcNext = pc;
      end
   end

endmodule

`default_nettype wire

// ==== src/reqAckSlot.sv ====
`default_nettype none

module reqAckSlot
   import execPkg::*;
#(
   parameter type payloadT = execOpT
) (
   input  logic    clk,
   input  logic    arstN,
   input  logic    inReq,
   output logic    inAck,
   input  payloadT inData,
   output logic    outReq,
   input  logic    outAck,
   output payloadT outData
);

   logic    full;
   logic    sent;
   logic    capture;
   payloadT dataQ;

   // Take a new payload only with the previous send fully closed
   assign capture = inReq & ~full & ~inAck;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         full   <= 1'b0;
         sent   <= 1'b0;
         inAck  <= 1'b0;
         outReq <= 1'b0;
      end else begin
         // Receive side
         if (capture) begin
            full  <= 1'b1;
            inAck <= 1'b1;
         end else if (!inReq) begin
            inAck <= 1'b0;
         end

         // Send side
         if (full && !sent && !outReq && !outAck) begin
            outReq <= 1'b1;
         end else if (outReq && outAck) begin
            outReq <= 1'b0;
            sent   <= 1'b1;
         end else if (sent && !outAck) begin
            // Ack dropped, slot is free again
            full <= 1'b0;
            sent <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (capture) begin
         dataQ <= inData;
      end
   end

   assign outData = dataQ;

endmodule

`default_nettype wire

// ==== tests/executeStageTb.sv ====
`default_nettype none

`include "exec_defines.svh"

module executeStageTb
   import execPkg::*;
();

   localparam int numOps    = 200;
   localparam int waitLimit = 200;

   logic                    clk;
   logic                    arstN;
   logic                    opReq;
   logic                    opAck;
   logic [`EXEC_DATA_W-1:0] rsData;
   logic [`EXEC_DATA_W-1:0] rtData;
   logic [`EXEC_DATA_W-1:0] pc;
   logic [`EXEC_DATA_W-1:0] imm;
   logic                    useImm;
   logic                    shortOff;
   logic                    jumpReg;
   aluOpT                   aluOp;
   brCondT                  brCond;
   logic [`EXEC_OFF_W-1:0]  brOffset;
   logic                    resReq;
   logic                    resAck;
   logic [`EXEC_DATA_W-1:0] aluOut;
   logic [`EXEC_DATA_W-1:0] pcNext;
   logic                    taken;

   logic [15:0] lfsrState;
   logic [15:0] delayState;
   logic [3:0]  shiftCount;
   execResT     expQ[$];
   execOpT      opQ[$];
   int          checks [6];
   int          errs [6];
   int          received;
   bit          timedOut;

   executeStage DUT (
      .clk      (clk),
      .arstN    (arstN),
      .opReq    (opReq),
      .opAck    (opAck),
      .rsData   (rsData),
      .rtData   (rtData),
      .pc       (pc),
      .imm      (imm),
      .useImm   (useImm),
      .shortOff (shortOff),
      .jumpReg  (jumpReg),
      .aluOp    (aluOp),
      .brCond   (brCond),
      .brOffset (brOffset),
      .resReq   (resReq),
      .resAck   (resAck),
      .aluOut   (aluOut),
      .pcNext   (pcNext),
      .taken    (taken)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Taps 16, 14, 13, 11
   function automatic logic [15:0] lfsrStep(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic takeBits(input int n, output logic [15:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[14:0], lfsrState[15]};
         lfsrState = lfsrStep(lfsrState);
      end
   endtask

   // Ack delays come from a stream of their own
   task automatic takeDelay(output logic [2:0] v);
      v = '0;
      for (int i = 0; i < 3; i++) begin
         v = {v[1:0], delayState[15]};
         delayState = lfsrStep(delayState);
      end
   endtask

   // Reference model of the stage
   function automatic execResT expectedResult(input execOpT op);
      logic [15:0] b;
      logic [15:0] res;
      logic [15:0] off;
      logic [15:0] tgt;
      logic        tk;
      execResT     r;
      b = op.useImm ? op.imm : op.rtData;
      case (op.aluOp)
         aluAdd:  res = op.rsData + b;
         aluSub:  res = op.rsData - b;
         aluAnd:  res = op.rsData & b;
         aluOr:   res = op.rsData | b;
         aluXor:  res = op.rsData ^ b;
         aluSll:  res = op.rsData << b[3:0];
         aluSrl:  res = op.rsData >> b[3:0];
         default: res = b;
      endcase
      off = op.shortOff ? {{8{op.brOffset[7]}}, op.brOffset[7:0]}
                        : {{5{op.brOffset[10]}}, op.brOffset};
      tgt = op.pc + off;
      case (op.brCond)
         brEq:     tk = (res == 16'h0000);
         brNe:     tk = (res != 16'h0000);
         brLt:     tk = res[15];
         brGe:     tk = ~res[15];
         brAlways: tk = 1'b1;
         default:  tk = 1'b0;
      endcase
      r.aluOut = res;
      r.taken  = tk;
      r.pcNext = op.jumpReg ? res : (tk ? tgt : op.pc);
      return r;
   endfunction

   // Random operation, biased toward zero results, shifts and PC wrap
   task automatic makeOp(output execOpT op);
      logic [15:0] r;
      logic [1:0]  sel;
      takeBits(16, r);
      op.rsData = r;
      takeBits(2, r);
      sel = r[1:0];
      takeBits(16, r);
      op.rtData = r;
      takeBits(16, r);
      op.imm = r;
      if (sel == 2'd0) begin
         op.rtData = op.rsData;
         op.imm    = op.rsData;
      end else if (sel == 2'd1) begin
         op.rtData = -op.rsData;
         op.imm    = -op.rsData;
      end
      takeBits(3, r);
      op.aluOp = aluOpT'(r[2:0]);
      if (op.aluOp == aluSll || op.aluOp == aluSrl) begin
         op.rtData[3:0] = shiftCount;
         op.imm[3:0]    = shiftCount;
         shiftCount     = shiftCount + 4'd1;
      end
      takeBits(1, r);
      op.useImm = r[0];
      takeBits(3, r);
      op.brCond = brCondT'(r[2:0]);
      takeBits(2, r);
      op.jumpReg = (r[1:0] == 2'd0);
      takeBits(1, r);
      op.shortOff = r[0];
      takeBits(11, r);
      op.brOffset = r[10:0];
      takeBits(16, r);
      op.pc = r;
      takeBits(2, r);
      if (r[1:0] == 2'd0) begin
         op.pc[15:4] = 12'hFFF;
      end
   endtask

   task automatic compareWord(input int test, input string name,
                              input logic [15:0] exp, input logic [15:0] act);
      checks[test]++;
      if (exp !== act) begin
         errs[test]++;
         $display("FAIL %s: expected %h, got %h (result %0d)", name, exp, act, received);
      end
   endtask

   task automatic noteTimeout(input string what);
      if (!timedOut) begin
         $display("Timeout: %s within %0d cycles", what, waitLimit);
      end
      timedOut = 1'b1;
   endtask

   function automatic string testLabel(input int i);
      case (i)
         0:       return "reset idle";
         1:       return "alu results";
         2:       return "branches";
         3:       return "register jumps";
         4:       return "ordering";
         default: return "result handshake";
      endcase
   endfunction

   task automatic reportTest(input int i);
      $display("test %0d %s: %0d checks, %0d errors", i + 1, testLabel(i), checks[i], errs[i]);
   endtask

   task automatic checkIdle();
      compareWord(0, "opAck", 16'd0, {15'd0, opAck});
      compareWord(0, "resReq", 16'd0, {15'd0, resReq});
      repeat (5) begin
         @(posedge clk);
         #1;
         compareWord(0, "resReq", 16'd0, {15'd0, resReq});
      end
      reportTest(0);
   endtask

   task automatic produce();
      execOpT op;
      int     cnt;
      for (int n = 0; n < numOps && !timedOut; n++) begin
         makeOp(op);
         rsData   = op.rsData;
         rtData   = op.rtData;
         pc       = op.pc;
         imm      = op.imm;
         useImm   = op.useImm;
         aluOp    = op.aluOp;
         brCond   = op.brCond;
         brOffset = op.brOffset;
         shortOff = op.shortOff;
         jumpReg  = op.jumpReg;
         expQ.push_back(expectedResult(op));
         opQ.push_back(op);
         opReq = 1'b1;
         cnt = 0;
         while (!opAck && cnt < waitLimit && !timedOut) begin
            @(posedge clk);
            #1;
            cnt++;
         end
         if (!opAck) noteTimeout("opAck did not rise");
         opReq = 1'b0;
         cnt = 0;
         while (opAck && cnt < waitLimit && !timedOut) begin
            @(posedge clk);
            #1;
            cnt++;
         end
         if (opAck) noteTimeout("opAck did not fall");
      end
   endtask

   task automatic consume();
      execResT    exp;
      execOpT     op;
      logic [2:0] d;
      int         cnt;
      bit         known;
      while (received < numOps && !timedOut) begin
         cnt = 0;
         while (!resReq && cnt < waitLimit && !timedOut) begin
            @(posedge clk);
            #1;
            cnt++;
         end
         if (!resReq) begin
            noteTimeout("no result arrived");
         end else begin
            checks[4]++;
            known = 1'b0;
            if (expQ.size() == 0) begin
               errs[4]++;
               $display("A result arrived with no operation outstanding");
            end else begin
               exp   = expQ.pop_front();
               op    = opQ.pop_front();
               known = 1'b1;
               compareWord(1, "aluOut", exp.aluOut, aluOut);
               compareWord(2, "taken", {15'd0, exp.taken}, {15'd0, taken});
               compareWord(op.jumpReg ? 3 : 2, "pcNext", exp.pcNext, pcNext);
            end
            // Outputs must hold while the ack is withheld
            takeDelay(d);
            repeat (d) begin
               @(posedge clk);
               #1;
               compareWord(5, "resReq", 16'd1, {15'd0, resReq});
               if (known) begin
                  compareWord(5, "aluOut", exp.aluOut, aluOut);
                  compareWord(5, "pcNext", exp.pcNext, pcNext);
                  compareWord(5, "taken", {15'd0, exp.taken}, {15'd0, taken});
               end
            end
            resAck = 1'b1;
            cnt = 0;
            while (resReq && cnt < waitLimit && !timedOut) begin
               @(posedge clk);
               #1;
               cnt++;
            end
            if (resReq) noteTimeout("resReq did not fall after resAck");
            resAck = 1'b0;
            received++;
         end
      end
   endtask

   initial begin
      int totalChecks;
      int totalErrs;
      opReq      = 1'b0;
      resAck     = 1'b0;
      rsData     = '0;
      rtData     = '0;
      pc         = '0;
      imm        = '0;
      useImm     = 1'b0;
      shortOff   = 1'b0;
      jumpReg    = 1'b0;
      aluOp      = aluAdd;
      brCond     = brNever;
      brOffset   = '0;
      lfsrState  = 16'd40543;
      delayState = 16'd40543;
      shiftCount = 4'd0;
      received   = 0;
      timedOut   = 1'b0;
      totalChecks = 0;
      totalErrs   = 0;
      for (int i = 0; i < 6; i++) begin
         checks[i] = 0;
         errs[i]   = 0;
      end
      arstN = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      arstN = 1'b1;
      checkIdle();
      fork
         produce();
         consume();
      join
      // No extra results once the queue has drained
      repeat (10) begin
         @(posedge clk);
         #1;
         compareWord(4, "resReq", 16'd0, {15'd0, resReq});
      end
      checks[4]++;
      if (received != numOps) begin
         errs[4]++;
         $display("Only %0d of %0d results arrived", received, numOps);
      end
      checks[4]++;
      if (expQ.size() != 0) begin
         errs[4]++;
         $display("%0d expected results were never delivered", expQ.size());
      end
      for (int i = 1; i < 6; i++) begin
         reportTest(i);
      end
      for (int i = 0; i < 6; i++) begin
         totalChecks += checks[i];
         totalErrs   += errs[i];
      end
      $display("total: %0d checks, %0d errors", totalChecks, totalErrs);
      if (totalErrs == 0 && !timedOut) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
